//--- project.f
source/core_pkg.sv
source/stage_reg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/regfile.sv
source/execute_unit.sv
source/core_top.sv
verification/core_checker.sv
verification/core_props.sv
verification/tb_core_top.sv

//--- Makefile
# Verilator build and run of the core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top import core_pkg::*; ();

    localparam int              PERIOD       = 8;
    localparam int              RESET_CYCLES = 10;
    localparam int              RAND_LEN     = 200;
    localparam int              SEED         = 32'hbbb8;
    localparam logic [XLEN-1:0] RESET_PC     = '0;
    // addi x0, x0, 0
    localparam logic [XLEN-1:0] NOP          = 32'h00000013;

    logic            clk = 1'b0;
    logic            arst_n;
    logic            rom_ce;
    logic [XLEN-1:0] rom_addr;
    logic [XLEN-1:0] rom_data;
    logic            ram_ce;
    logic            ram_we;
    logic [3:0]      ram_sel;
    logic [XLEN-1:0] ram_addr;
    logic [XLEN-1:0] ram_data;

    logic [XLEN-1:0] rom_mem [256];
    logic [XLEN-1:0] rom_word;
    logic [XLEN-1:0] prog_q [$];
    int              prog_len     = 0;
    int              tb_errors    = 0;
    int              tests_passed = 0;
    int              tests_failed = 0;
    logic [63:0]     deadline     = '0;

    always #(PERIOD / 2) clk = ~clk;

    core_top #(
        .RESET_PC(RESET_PC)
    ) core_top_i (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .rom_ce_o  (rom_ce),
        .rom_addr_o(rom_addr),
        .rom_data_i(rom_data),
        .ram_ce_o  (ram_ce),
        .ram_we_o  (ram_we),
        .ram_sel_o (ram_sel),
        .ram_addr_o(ram_addr),
        .ram_data_o(ram_data)
    );

    core_checker core_checker_i (
        .clk_i     (clk),
        .arst_n_i  (arst_n),
        .ram_we_i  (ram_we),
        .ram_addr_i(ram_addr),
        .ram_data_i(ram_data)
    );

    bind core_top core_props core_props_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rom_ce_i  (rom_ce_o),
        .rom_addr_i(rom_addr_o),
        .ram_ce_i  (ram_ce_o),
        .ram_we_i  (ram_we_o),
        .ram_sel_i (ram_sel_o)
    );

    // combinational rom that returns nops past the program end
    assign rom_word = (rom_addr - RESET_PC) >> 2;
    assign rom_data = (rom_word < XLEN'(prog_len)) ? rom_mem[rom_word[7:0]] : NOP;

    always @(negedge clk) begin
        if (deadline != '0 && $time > deadline) begin
            $display("timeout: a test ran past its time budget");
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic void emit(input logic [31:0] word);
        prog_q.push_back(word);
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        rd  = 5'($urandom % 8);
        rs1 = 5'($urandom % 8);
        rs2 = 5'($urandom % 8);
        imm = 12'($urandom);
        case ($urandom % 13)
            0:       return reg_op(F7_BASE, F3_ADD, rd, rs1, rs2);
            1:       return reg_op(F7_SUB, F3_ADD, rd, rs1, rs2);
            2:       return reg_op(F7_BASE, F3_AND, rd, rs1, rs2);
            3:       return reg_op(F7_BASE, F3_OR, rd, rs1, rs2);
            4:       return reg_op(F7_BASE, F3_XOR, rd, rs1, rs2);
            5:       return imm_op(F3_ADD, rd, rs1, imm);
            6:       return imm_op(F3_AND, rd, rs1, imm);
            7:       return imm_op(F3_OR, rd, rs1, imm);
            8:       return imm_op(F3_XOR, rd, rs1, imm);
            9:       return upper_imm(rd, 20'($urandom));
            default: return store_word(rs2, rs1, imm);
        endcase
    endfunction

    // in-order model of the program where every SW becomes one expected store
    function automatic void build_expected();
        logic [31:0] regs [32];
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] res;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic        wr;
        regs = '{default: '0};
        foreach (prog_q[k]) begin
            inst  = prog_q[k];
            f7    = inst[31:25];
            f3    = inst[14:12];
            a     = regs[inst[19:15]];
            b     = regs[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            res   = '0;
            wr    = 1'b0;
            case (inst[6:0])
                7'b0110011: begin
                    wr = 1'b1;
                    case ({f7, f3})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_111: res = a & b;
                        default:         wr  = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr = 1'b1;
                    case (f3)
                        3'b000:  res = a + imm_i;
                        3'b100:  res = a ^ imm_i;
                        3'b110:  res = a | imm_i;
                        3'b111:  res = a & imm_i;
                        default: wr  = 1'b0;
                    endcase
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    res = {inst[31:12], 12'b0};
                end
                7'b0100011: begin
                    if (f3 == 3'b010) begin
                        core_checker_i.push_expected(a + imm_s, b);
                    end
                end
                default: begin
                    wr = 1'b0;
                end
            endcase
            if (wr && inst[11:7] != 5'd0) begin
                regs[inst[11:7]] = res;
            end
        end
    endfunction

    task automatic run_test(input string name);
        int errs_before;
        errs_before = tb_errors + core_checker_i.error_count;
        @(negedge clk);
        arst_n = 1'b0;
        prog_len = prog_q.size();
        foreach (prog_q[k]) begin
            rom_mem[8'(k)] = prog_q[k];
        end
        core_checker_i.clear_expected();
        build_expected();
        deadline = $time + 64'((prog_len + RESET_CYCLES + 20) * PERIOD * 2);
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (rom_ce !== 1'b0 || ram_we !== 1'b0) begin
                $display("MISMATCH at %0t: rom_ce %b ram_we %b in reset, expected both low",
                         $time, rom_ce, ram_we);
                tb_errors++;
            end
        end
        arst_n = 1'b1;
        #1;
        if (rom_ce !== 1'b0 || ram_we !== 1'b0) begin
            $display("MISMATCH at %0t: rom_ce %b ram_we %b after reset, expected both low",
                     $time, rom_ce, ram_we);
            tb_errors++;
        end
        @(negedge clk);
        if (rom_ce !== 1'b1 || rom_addr !== RESET_PC) begin
            $display("MISMATCH at %0t: first fetch expected %h, got %h with rom_ce %b",
                     $time, RESET_PC, rom_addr, rom_ce);
            tb_errors++;
        end
        // run until fetch is past the program and the pipeline has drained
        while (rom_addr < RESET_PC + XLEN'(4 * (prog_len + 4))) begin
            @(negedge clk);
        end
        if (core_checker_i.pending() != 0) begin
            $display("[%0t] %0d expected stores were never issued by the core",
                     $time, core_checker_i.pending());
            tb_errors++;
        end
        if (tb_errors + core_checker_i.error_count == errs_before) begin
            tests_passed++;
            $display("test %s: pass, %0d instructions", name, prog_len);
        end else begin
            tests_failed++;
            $display("test %s: FAIL, %0d instructions", name, prog_len);
        end
        prog_q.delete();
    endtask

    initial begin
        arst_n = 1'b0;
        void'($urandom(SEED));

        emit(imm_op(F3_ADD, 1, 0, 12'h055));
        emit(store_word(1, 0, 12'h040));
        run_test("reset_quiet");

        emit(upper_imm(1, 20'h12345));
        emit(imm_op(F3_ADD, 1, 1, 12'h678));
        emit(store_word(1, 0, 12'h000));
        emit(imm_op(F3_ADD, 2, 0, 12'hfff));
        emit(imm_op(F3_AND, 3, 2, 12'h0f0));
        emit(store_word(3, 0, 12'h004));
        emit(imm_op(F3_OR, 4, 3, 12'h703));
        emit(imm_op(F3_XOR, 5, 4, 12'h7ff));
        emit(imm_op(F3_ADD, 6, 0, 12'h100));
        emit(store_word(4, 6, 12'hff8));
        emit(store_word(5, 6, 12'hffc));
        emit(store_word(2, 0, 12'h00c));
        run_test("imm_lui");

        emit(imm_op(F3_ADD, 1, 0, 12'h007));
        emit(imm_op(F3_ADD, 2, 0, 12'h003));
        // producer one slot ahead
        emit(reg_op(F7_BASE, F3_ADD, 3, 1, 2));
        emit(reg_op(F7_SUB, F3_ADD, 4, 3, 1));
        emit(store_word(4, 0, 12'h010));
        // two slots ahead
        emit(reg_op(F7_BASE, F3_XOR, 5, 1, 2));
        emit(NOP);
        emit(reg_op(F7_BASE, F3_OR, 6, 5, 4));
        // three slots ahead through register file write-through
        emit(reg_op(F7_BASE, F3_AND, 7, 6, 1));
        emit(NOP);
        emit(NOP);
        emit(reg_op(F7_SUB, F3_ADD, 8, 2, 7));
        emit(store_word(6, 0, 12'h014));
        emit(store_word(8, 7, 12'h018));
        emit(reg_op(F7_BASE, F3_ADD, 9, 8, 8));
        emit(store_word(9, 9, 12'h020));
        // youngest of several writers to x10 must win
        emit(imm_op(F3_ADD, 10, 0, 12'h001));
        emit(imm_op(F3_ADD, 10, 10, 12'h002));
        emit(imm_op(F3_ADD, 10, 10, 12'h004));
        emit(store_word(10, 0, 12'h024));
        run_test("rr_forward");

        emit(imm_op(F3_ADD, 1, 0, 12'h009));
        emit(imm_op(F3_ADD, 2, 0, 12'h0a5));
        emit(imm_op(F3_ADD, 0, 1, 12'h123));
        emit(upper_imm(0, 20'habcde));
        emit(reg_op(F7_BASE, F3_ADD, 0, 1, 1));
        emit(store_word(0, 0, 12'h030));
        // lw, slli, mul, sub with xor funct3, sb, beq, all-ones
        emit(32'h00002103);
        emit(imm_op(3'b001, 2, 1, 12'h004));
        emit(reg_op(7'b0000001, F3_ADD, 2, 1, 1));
        emit(reg_op(F7_SUB, F3_XOR, 2, 1, 1));
        emit(32'h00208023);
        emit(32'h00000063);
        emit(32'hffffffff);
        emit(store_word(2, 0, 12'h034));
        emit(store_word(0, 1, 12'h038));
        run_test("x0_unknown");

        for (int n = 0; n < RAND_LEN; n++) begin
            emit(random_inst());
        end
        run_test("random_mix");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/core_props.sv
`timescale 1ns/1ps
`default_nettype none

module core_props import core_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            rom_ce_i,
    input  logic [XLEN-1:0] rom_addr_i,
    input  logic            ram_ce_i,
    input  logic            ram_we_i,
    input  logic [3:0]      ram_sel_i
);

    store_strobe: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ram_we_i |-> ram_ce_i && ram_sel_i == 4'hf)
        else $error("store strobe without chip enable or full byte select");

    rom_aligned: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rom_addr_i[1:0] == 2'b00)
        else $error("instruction address %h is not word aligned", rom_addr_i);

    // sequential fetch only, no redirects exist
    pc_step: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rom_ce_i && $past(rom_ce_i) |-> rom_addr_i == $past(rom_addr_i) + XLEN'(4))
        else $error("instruction address %h did not advance by one word", rom_addr_i);

endmodule

`default_nettype wire

//--- verification/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker import core_pkg::*; (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            ram_we_i,
    input  logic [XLEN-1:0] ram_addr_i,
    input  logic [XLEN-1:0] ram_data_i
);

    logic [XLEN-1:0] exp_addr_q [$];
    logic [XLEN-1:0] exp_data_q [$];
    logic [XLEN-1:0] exp_addr;
    logic [XLEN-1:0] exp_data;
    int              error_count = 0;
    int              store_count = 0;

    function automatic void push_expected(input logic [XLEN-1:0] addr,
                                          input logic [XLEN-1:0] data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endfunction

    function automatic void clear_expected();
        exp_addr_q.delete();
        exp_data_q.delete();
    endfunction

    function automatic int pending();
        return exp_addr_q.size();
    endfunction

    // a store strobe lasts one full cycle, sampled in its middle
    initial begin
        forever begin
            @(negedge clk_i);
            if (arst_n_i && ram_we_i) begin
                if (exp_addr_q.size() == 0) begin
                    $display("[%0t] store of %h to %h arrived when no store was expected",
                             $time, ram_data_i, ram_addr_i);
                    error_count++;
                end else begin
                    exp_addr = exp_addr_q.pop_front();
                    exp_data = exp_data_q.pop_front();
                    if (ram_addr_i !== exp_addr) begin
                        $display("MISMATCH at %0t: store %0d address expected %h, got %h",
                                 $time, store_count, exp_addr, ram_addr_i);
                        error_count++;
                    end
                    if (ram_data_i !== exp_data) begin
                        $display("MISMATCH at %0t: store %0d data expected %h, got %h",
                                 $time, store_count, exp_data, ram_data_i);
                        error_count++;
                    end
                end
                store_count++;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    // instruction rom, combinational read
    output logic            rom_ce_o,
    output logic [XLEN-1:0] rom_addr_o,
    input  logic [XLEN-1:0] rom_data_i,
    // data ram, write only
    output logic            ram_ce_o,
    output logic            ram_we_o,
    output logic [3:0]      ram_sel_o,
    output logic [XLEN-1:0] ram_addr_o,
    output logic [XLEN-1:0] ram_data_o
);

    logic [XLEN-1:0]       pc;
    logic                  fetch_ce;
    if_id_t                if_id_d;
    if_id_t                if_id_q;
    id_ex_t                id_ex_d;
    id_ex_t                id_ex_q;
    ex_mem_t               ex_mem_d;
    ex_mem_t               ex_mem_q;
    wb_t                   ex_fwd;
    wb_t                   mem_fwd;
    wb_t                   wb_q;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_unit_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .pc_o    (pc),
        .ce_o    (fetch_ce)
    );

    assign rom_ce_o   = fetch_ce;
    assign rom_addr_o = pc;

    // an all-zero word decodes as a no-op, so idle fetch cycles inject nothing
    assign if_id_d.pc   = pc;
    assign if_id_d.inst = fetch_ce ? rom_data_i : '0;

    stage_reg #(.payload_t(if_id_t)) if_id_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .d_i(if_id_d), .q_o(if_id_q)
    );

    decode_unit decode_unit_i (
        .inst_i    (if_id_q),
        .rs1_addr_o(rs1_addr),
        .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data),
        .rs2_data_i(rs2_data),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .decoded_o (id_ex_d)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .d_i(id_ex_d), .q_o(id_ex_q)
    );

    execute_unit execute_unit_i (
        .op_i    (id_ex_q),
        .result_o(ex_mem_d),
        .fwd_o   (ex_fwd)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    // memory stage
    assign ram_ce_o   = ex_mem_q.store;
    assign ram_we_o   = ex_mem_q.store;
    assign ram_sel_o  = {4{ex_mem_q.store}};
    assign ram_addr_o = ex_mem_q.result;
    assign ram_data_o = ex_mem_q.store_data;

    assign mem_fwd.we   = ex_mem_q.rd_we;
    assign mem_fwd.rd   = ex_mem_q.rd;
    assign mem_fwd.data = ex_mem_q.result;

    stage_reg #(.payload_t(wb_t)) mem_wb_i (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .d_i(mem_fwd), .q_o(wb_q)
    );

    regfile regfile_i (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .wb_i      (wb_q),
        .rs1_addr_i(rs1_addr),
        .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data),
        .rs2_data_o(rs2_data)
    );

endmodule

`default_nettype wire

//--- source/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execute_unit import core_pkg::*; (
    input  id_ex_t  op_i,
    output ex_mem_t result_o,
    output wb_t     fwd_o
);

    logic [XLEN-1:0] alu_out;

    always_comb begin
        case (op_i.alu_op)
            ALU_ADD:    alu_out = op_i.opa + op_i.opb;
            ALU_SUB:    alu_out = op_i.opa - op_i.opb;
            ALU_AND:    alu_out = op_i.opa & op_i.opb;
            ALU_OR:     alu_out = op_i.opa | op_i.opb;
            ALU_XOR:    alu_out = op_i.opa ^ op_i.opb;
            ALU_PASS_B: alu_out = op_i.opb;
            default:    alu_out = '0;
        endcase
    end

    // for a store the alu output is the ram address
    assign result_o.result     = alu_out;
    assign result_o.store_data = op_i.store_data;
    assign result_o.rd         = op_i.rd;
    assign result_o.rd_we      = op_i.rd_we;
    assign result_o.store      = op_i.store;

    // back-to-back dependency path into decode
    assign fwd_o.we   = op_i.rd_we;
    assign fwd_o.rd   = op_i.rd;
    assign fwd_o.data = alu_out;

endmodule

`default_nettype wire

//--- source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile import core_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  wb_t                   wb_i,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    logic [XLEN-1:0] regs [32];
    logic            wr_en;

    assign wr_en = wb_i.we && (wb_i.rd != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // same-cycle write shows through to the readers
    always_comb begin
        rs1_data_o = regs[rs1_addr_i];
        if (wr_en && wb_i.rd == rs1_addr_i) begin
            rs1_data_o = wb_i.data;
        end
        rs2_data_o = regs[rs2_addr_i];
        if (wr_en && wb_i.rd == rs2_addr_i) begin
            rs2_data_o = wb_i.data;
        end
    end

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`timescale 1ns/1ps
`default_nettype none

module decode_unit import core_pkg::*; (
    input  if_id_t                inst_i,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  wb_t                   ex_fwd_i,
    input  wb_t                   mem_fwd_i,
    output id_ex_t                decoded_o
);

    logic [XLEN-1:0] inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    // youngest producer wins, x0 never forwards
    function automatic logic [XLEN-1:0] pick_operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [XLEN-1:0]       rf_data,
        input wb_t                   ex_fwd,
        input wb_t                   mem_fwd
    );
        if (addr == '0) begin
            return '0;
        end else if (ex_fwd.we && ex_fwd.rd == addr) begin
            return ex_fwd.data;
        end else if (mem_fwd.we && mem_fwd.rd == addr) begin
            return mem_fwd.data;
        end
        return rf_data;
    endfunction

    assign inst   = inst_i.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    assign rs1_val = pick_operand(rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
    assign rs2_val = pick_operand(rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        decoded_o            = '0;
        decoded_o.opa        = rs1_val;
        decoded_o.opb        = rs2_val;
        decoded_o.store_data = rs2_val;
        case (opcode)
            OPC_OP: begin
                decoded_o.rd    = inst[11:7];
                decoded_o.rd_we = 1'b1;
                if (funct3 == F3_ADD && funct7 == F7_SUB) begin
                    decoded_o.alu_op = ALU_SUB;
                end else if (funct7 != F7_BASE) begin
                    decoded_o.rd_we = 1'b0;
                end else begin
                    case (funct3)
                        F3_ADD:  decoded_o.alu_op = ALU_ADD;
                        F3_XOR:  decoded_o.alu_op = ALU_XOR;
                        F3_OR:   decoded_o.alu_op = ALU_OR;
                        F3_AND:  decoded_o.alu_op = ALU_AND;
                        default: decoded_o.rd_we  = 1'b0;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                decoded_o.rd    = inst[11:7];
                decoded_o.rd_we = 1'b1;
                decoded_o.opb   = imm_i;
                case (funct3)
                    F3_ADD:  decoded_o.alu_op = ALU_ADD;
                    F3_XOR:  decoded_o.alu_op = ALU_XOR;
                    F3_OR:   decoded_o.alu_op = ALU_OR;
                    F3_AND:  decoded_o.alu_op = ALU_AND;
                    // shifts and compares are not kept
                    default: decoded_o.rd_we  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                decoded_o.rd     = inst[11:7];
                decoded_o.rd_we  = 1'b1;
                decoded_o.opb    = imm_u;
                decoded_o.alu_op = ALU_PASS_B;
            end
            OPC_STORE: begin
                // only word stores, address is rs1 + offset
                decoded_o.alu_op = ALU_ADD;
                decoded_o.opb    = imm_s;
                decoded_o.store  = (funct3 == F3_SW);
            end
            default: begin
                decoded_o.rd_we = 1'b0;
            end
        endcase
        if (!decoded_o.rd_we) begin
            decoded_o.rd = '0;
        end
    end

endmodule

`default_nettype wire

//--- source/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import core_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    output logic [XLEN-1:0] pc_o,
    output logic            ce_o
);

    // ce comes up one cycle after reset release, pc only moves once fetching
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ce_o <= 1'b0;
            pc_o <= RESET_PC;
        end else begin
            ce_o <= 1'b1;
            if (ce_o) begin
                pc_o <= pc_o + XLEN'(4);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // all-zero payload carries no write and no store
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

//--- source/core_pkg.sv
`default_nettype none

package core_pkg;

    parameter int XLEN       = 32;
    parameter int REG_ADDR_W = 5;

    // major opcodes
    parameter logic [6:0] OPC_OP     = 7'b0110011;
    parameter logic [6:0] OPC_OP_IMM = 7'b0010011;
    parameter logic [6:0] OPC_LUI    = 7'b0110111;
    parameter logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 encodings of the kept operations
    parameter logic [2:0] F3_ADD = 3'b000;
    parameter logic [2:0] F3_XOR = 3'b100;
    parameter logic [2:0] F3_OR  = 3'b110;
    parameter logic [2:0] F3_AND = 3'b111;
    parameter logic [2:0] F3_SW  = 3'b010;

    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_PASS_B = 3'd5
    } alu_op_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        alu_op_t               alu_op;
        logic [XLEN-1:0]       opa;
        logic [XLEN-1:0]       opb;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic                  store;
    } id_ex_t;

    // result doubles as the store address
    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  rd_we;
        logic                  store;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire
